/* include/rv_chk_defs.svh */
`ifndef RV_CHK_DEFS_SVH
`define RV_CHK_DEFS_SVH

// datapath widths
`define RV_XLEN   32              // data and pc width
`define RV_REG_W  5               // register index width

// base opcodes, bits [6:0] of the word
`define RV_OPC_R      7'b0110011  // register-register alu
`define RV_OPC_I      7'b0010011  // alu with immediate
`define RV_OPC_IL     7'b0000011  // loads
`define RV_OPC_S      7'b0100011  // stores
`define RV_OPC_B      7'b1100011  // conditional branches
`define RV_OPC_JAL    7'b1101111
`define RV_OPC_JALR   7'b1100111
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_AUIPC  7'b0010111
`define RV_OPC_FENCE  7'b0001111
`define RV_OPC_SYS    7'b1110011  // ecall, ebreak

// funct3 of the checked instructions
`define RV_F3_XOR     3'b100
`define RV_F3_BLT     3'b100

// funct7 values seen on OP and OP-IMM shifts
`define RV_F7_BASE    7'b0000000
`define RV_F7_ALT     7'b0100000  // sub, sra, srai

// check class of a retired record
`define RV_CLS_W        3
`define RV_CLS_ILLEGAL  3'd0
`define RV_CLS_OTHER    3'd1      // legal, not checked
`define RV_CLS_XORI     3'd2
`define RV_CLS_AUIPC    3'd3
`define RV_CLS_BLT      3'd4
`define RV_CLS_JAL      3'd5

// pc step of a 32-bit instruction
`define RV_PC_STEP    32'd4

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing -f rv_retire_checker.f \
        --top-module tb_rv_retire_checker -o sim_tb 2>&1 \
    && ./obj_dir/sim_tb 2>&1)
echo "$out"

echo "$out" | grep -qx "TEST OK" && exit 0 || exit 1

/* rv_retire_checker.f */
+incdir+include
src/rv_chk_pkg.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_retire_checker.sv
test/rv_chk_monitor.sv
test/tb_rv_retire_checker.sv

/* src/rv_chk_pkg.sv */
`default_nettype none

`include "rv_chk_defs.svh"

package rv_chk_pkg;

    typedef struct packed {
        logic [6:0]           funct7;
        logic [`RV_REG_W-1:0] rs2;
        logic [`RV_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [`RV_REG_W-1:0] rd;
        logic [6:0]           opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0]          imm;
        logic [`RV_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [`RV_REG_W-1:0] rd;
        logic [6:0]           opcode;
    } i_view_t;

    typedef struct packed {
        logic [6:0]           imm_hi;
        logic [`RV_REG_W-1:0] rs2;
        logic [`RV_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [4:0]           imm_lo;
        logic [6:0]           opcode;
    } s_view_t;

    // branch offset bits are scattered around the register fields
    typedef struct packed {
        logic                 imm12;
        logic [5:0]           imm10_5;
        logic [`RV_REG_W-1:0] rs2;
        logic [`RV_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [3:0]           imm4_1;
        logic                 imm11;
        logic [6:0]           opcode;
    } b_view_t;

    typedef struct packed {
        logic [19:0]          imm20;   // upper immediate
        logic [`RV_REG_W-1:0] rd;
        logic [6:0]           opcode;
    } u_view_t;

    typedef struct packed {
        logic                 imm20;
        logic [9:0]           imm10_1;
        logic                 imm11;
        logic [7:0]           imm19_12;
        logic [`RV_REG_W-1:0] rd;
        logic [6:0]           opcode;
    } j_view_t;

    // one instruction word, six format views
    typedef union packed {
        r_view_t r;
        i_view_t i;
        s_view_t s;
        b_view_t b;
        u_view_t u;
        j_view_t j;
    } insn_u;

endpackage

`default_nettype wire

/* src/rv_decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_chk_defs.svh"

module rv_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_i,
    input  logic [`RV_XLEN-1:0]   inst_i,
    input  logic [`RV_XLEN-1:0]   pc_i,
    input  logic [`RV_XLEN-1:0]   rs1_val_i,
    input  logic [`RV_XLEN-1:0]   rs2_val_i,
    input  logic [`RV_XLEN-1:0]   wb_val_i,
    input  logic [`RV_REG_W-1:0]  wb_rd_i,
    input  logic                  wb_we_i,
    output logic                  ack_o,
    output logic                  d_valid_o,
    output logic [`RV_CLS_W-1:0]  d_class_o,
    output rv_chk_pkg::insn_u     d_insn_o,
    output logic [`RV_XLEN-1:0]   d_pc_o,
    output logic [`RV_XLEN-1:0]   d_rs1_o,
    output logic [`RV_XLEN-1:0]   d_rs2_o,
    output logic [`RV_XLEN-1:0]   d_wb_val_o,
    output logic [`RV_REG_W-1:0]  d_wb_rd_o,
    output logic                  d_wb_we_o
);
    rv_chk_pkg::insn_u    in_w;
    logic                 capture;
    logic                 legal;
    logic [`RV_CLS_W-1:0] cls;

    assign in_w    = inst_i;
    assign capture = req_i && !ack_o;   // first half of the four-phase cycle

    // legality of a base rv32i word
    always_comb begin
        legal = 1'b0;
        case (in_w.r.opcode)
            `RV_OPC_LUI, `RV_OPC_AUIPC, `RV_OPC_JAL: legal = 1'b1;
            `RV_OPC_JALR:  legal = (in_w.i.funct3 == 3'b000);
            `RV_OPC_B:     legal = !(in_w.b.funct3 inside {3'b010, 3'b011});
            `RV_OPC_IL:    legal = in_w.i.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
            `RV_OPC_S:     legal = in_w.s.funct3 inside {3'b000, 3'b001, 3'b010};
            `RV_OPC_I: begin
                case (in_w.r.funct3)
                    3'b001:  legal = (in_w.r.funct7 == `RV_F7_BASE);   // slli
                    3'b101:  legal = in_w.r.funct7 inside {`RV_F7_BASE, `RV_F7_ALT};
                    default: legal = 1'b1;
                endcase
            end
            `RV_OPC_R: begin
                legal = (in_w.r.funct7 == `RV_F7_BASE) ||
                        ((in_w.r.funct7 == `RV_F7_ALT) && (in_w.r.funct3 inside {3'b000, 3'b101}));
            end
            `RV_OPC_FENCE: legal = (in_w.i.funct3 == 3'b000);
            `RV_OPC_SYS: begin
                // only imm bit 0 may be set (ecall or ebreak)
                legal = (in_w.i.imm[11:1] == 11'd0) && (in_w.i.rs1 == '0) &&
                        (in_w.i.funct3 == 3'b000) && (in_w.i.rd == '0);
            end
            default: legal = 1'b0;
        endcase
    end

    always_comb begin
        if (!legal) begin
            cls = `RV_CLS_ILLEGAL;
        end else if ((in_w.r.opcode == `RV_OPC_I) && (in_w.i.funct3 == `RV_F3_XOR)) begin
            cls = `RV_CLS_XORI;
        end else if (in_w.r.opcode == `RV_OPC_AUIPC) begin
            cls = `RV_CLS_AUIPC;
        end else if ((in_w.r.opcode == `RV_OPC_B) && (in_w.b.funct3 == `RV_F3_BLT)) begin
            cls = `RV_CLS_BLT;
        end else if (in_w.r.opcode == `RV_OPC_JAL) begin
            cls = `RV_CLS_JAL;
        end else begin
            cls = `RV_CLS_OTHER;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_o     <= 1'b0;
            d_valid_o <= 1'b0;
        end else begin
            d_valid_o <= capture;     // one pulse per record
            if (capture) begin
                ack_o <= 1'b1;
            end else if (!req_i) begin
                ack_o <= 1'b0;        // producer has dropped req
            end
        end
    end

    // record payload
    always_ff @(posedge clk) begin
        if (capture) begin
            d_class_o  <= cls;
            d_insn_o   <= in_w;
            d_pc_o     <= pc_i;
            d_rs1_o    <= rs1_val_i;
            d_rs2_o    <= rs2_val_i;
            d_wb_val_o <= wb_val_i;
            d_wb_rd_o  <= wb_rd_i;
            d_wb_we_o  <= wb_we_i;
        end
    end

endmodule

`default_nettype wire

/* src/rv_execute.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_chk_defs.svh"

module rv_execute (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  d_valid_i,
    input  logic [`RV_CLS_W-1:0]  d_class_i,
    input  rv_chk_pkg::insn_u     d_insn_i,
    input  logic [`RV_XLEN-1:0]   d_pc_i,
    input  logic [`RV_XLEN-1:0]   d_rs1_i,
    input  logic [`RV_XLEN-1:0]   d_rs2_i,
    input  logic [`RV_XLEN-1:0]   d_wb_val_i,
    input  logic [`RV_REG_W-1:0]  d_wb_rd_i,
    input  logic                  d_wb_we_i,
    output logic                  e_valid_o,
    output logic [`RV_CLS_W-1:0]  e_class_o,
    output logic [`RV_XLEN-1:0]   e_golden_o,
    output logic [`RV_REG_W-1:0]  e_rd_o,
    output logic [`RV_XLEN-1:0]   e_pc_o,
    output logic [`RV_XLEN-1:0]   e_wb_val_o,
    output logic [`RV_REG_W-1:0]  e_wb_rd_o,
    output logic                  e_wb_we_o
);
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_j;
    logic                blt_taken;
    logic [`RV_XLEN-1:0] golden;

    // sign-extended immediates from the matching views
    assign imm_i = {{20{d_insn_i.i.imm[11]}}, d_insn_i.i.imm};
    assign imm_u = {d_insn_i.u.imm20, 12'b0};
    assign imm_b = {{19{d_insn_i.b.imm12}}, d_insn_i.b.imm12, d_insn_i.b.imm11,
                    d_insn_i.b.imm10_5, d_insn_i.b.imm4_1, 1'b0};
    assign imm_j = {{11{d_insn_i.j.imm20}}, d_insn_i.j.imm20, d_insn_i.j.imm19_12,
                    d_insn_i.j.imm11, d_insn_i.j.imm10_1, 1'b0};

    assign blt_taken = $signed(d_rs1_i) < $signed(d_rs2_i);

    always_comb begin
        case (d_class_i)
            `RV_CLS_XORI:  golden = d_rs1_i ^ imm_i;
            `RV_CLS_AUIPC: golden = d_pc_i + imm_u;
            `RV_CLS_BLT: begin
                // taken target or fall-through
                golden = blt_taken ? (d_pc_i + imm_b) : (d_pc_i + `RV_PC_STEP);
            end
            `RV_CLS_JAL:   golden = d_pc_i + imm_j;
            default:       golden = '0;   // illegal and unchecked words
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            e_valid_o <= 1'b0;
        end else begin
            e_valid_o <= d_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (d_valid_i) begin
            e_class_o  <= d_class_i;
            e_golden_o <= golden;
            e_rd_o     <= d_insn_i.r.rd;  // same bits in every view that has rd
            e_pc_o     <= d_pc_i;
            e_wb_val_o <= d_wb_val_i;
            e_wb_rd_o  <= d_wb_rd_i;
            e_wb_we_o  <= d_wb_we_i;
        end
    end

endmodule

`default_nettype wire

/* src/rv_result.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_chk_defs.svh"

module rv_result (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  e_valid_i,
    input  logic [`RV_CLS_W-1:0]  e_class_i,
    input  logic [`RV_XLEN-1:0]   e_golden_i,
    input  logic [`RV_REG_W-1:0]  e_rd_i,
    input  logic [`RV_XLEN-1:0]   e_pc_i,
    input  logic [`RV_XLEN-1:0]   e_wb_val_i,
    input  logic [`RV_REG_W-1:0]  e_wb_rd_i,
    input  logic                  e_wb_we_i,
    output logic                  stat_valid_o,
    output logic [`RV_CLS_W-1:0]  stat_class_o,
    output logic                  stat_err_o,
    output logic [`RV_XLEN-1:0]   stat_expected_o,
    output logic [`RV_XLEN-1:0]   stat_actual_o,
    output logic                  flow_valid_o,
    output logic                  flow_err_o,
    output logic [`RV_XLEN-1:0]   flow_expected_o,
    output logic [`RV_XLEN-1:0]   flow_actual_o
);
    logic                pend_q;       // a branch target waits for the next pc
    logic [`RV_XLEN-1:0] pend_target_q;
    logic                err;
    logic [`RV_XLEN-1:0] expected;
    logic [`RV_XLEN-1:0] actual;
    logic                is_flow;

    assign is_flow = (e_class_i == `RV_CLS_BLT) || (e_class_i == `RV_CLS_JAL);

    always_comb begin
        expected = e_golden_i;
        actual   = e_wb_val_i;
        err      = 1'b0;
        case (e_class_i)
            `RV_CLS_XORI, `RV_CLS_AUIPC: begin
                err = (e_wb_val_i != e_golden_i) || (e_wb_rd_i != e_rd_i) ||
                      (!e_wb_we_i && (e_rd_i != '0));
            end
            `RV_CLS_ILLEGAL: begin
                // must leave the register file alone
                expected = '0;
                actual   = {{(`RV_XLEN-1){1'b0}}, e_wb_we_i};
                err      = e_wb_we_i;
            end
            default: err = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stat_valid_o <= 1'b0;
            flow_valid_o <= 1'b0;
            pend_q       <= 1'b0;
        end else begin
            stat_valid_o <= e_valid_i;
            flow_valid_o <= e_valid_i && pend_q;
            if (e_valid_i) begin
                pend_q <= is_flow;   // clear, or replace with a new target
            end
        end
    end

    always_ff @(posedge clk) begin
        if (e_valid_i) begin
            stat_class_o    <= e_class_i;
            stat_err_o      <= err;
            stat_expected_o <= expected;
            stat_actual_o   <= actual;
            flow_err_o      <= pend_q && (e_pc_i != pend_target_q);
            flow_expected_o <= pend_target_q;
            flow_actual_o   <= e_pc_i;
            if (is_flow) begin
                pend_target_q <= e_golden_i;
            end
        end
    end

endmodule

`default_nettype wire

/* src/rv_retire_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_chk_defs.svh"

module rv_retire_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_i,
    output logic                  ack_o,
    input  logic [`RV_XLEN-1:0]   inst_i,
    input  logic [`RV_XLEN-1:0]   pc_i,
    input  logic [`RV_XLEN-1:0]   rs1_val_i,
    input  logic [`RV_XLEN-1:0]   rs2_val_i,
    input  logic [`RV_XLEN-1:0]   wb_val_i,
    input  logic [`RV_REG_W-1:0]  wb_rd_i,
    input  logic                  wb_we_i,
    output logic                  stat_valid_o,
    output logic [`RV_CLS_W-1:0]  stat_class_o,
    output logic                  stat_err_o,
    output logic [`RV_XLEN-1:0]   stat_expected_o,
    output logic [`RV_XLEN-1:0]   stat_actual_o,
    output logic                  flow_valid_o,
    output logic                  flow_err_o,
    output logic [`RV_XLEN-1:0]   flow_expected_o,
    output logic [`RV_XLEN-1:0]   flow_actual_o
);
    // decode to execute
    logic                 d_valid;
    logic [`RV_CLS_W-1:0] d_class;
    rv_chk_pkg::insn_u    d_insn;
    logic [`RV_XLEN-1:0]  d_pc;
    logic [`RV_XLEN-1:0]  d_rs1;
    logic [`RV_XLEN-1:0]  d_rs2;
    logic [`RV_XLEN-1:0]  d_wb_val;
    logic [`RV_REG_W-1:0] d_wb_rd;
    logic                 d_wb_we;

    // execute to result
    logic                 e_valid;
    logic [`RV_CLS_W-1:0] e_class;
    logic [`RV_XLEN-1:0]  e_golden;
    logic [`RV_REG_W-1:0] e_rd;
    logic [`RV_XLEN-1:0]  e_pc;
    logic [`RV_XLEN-1:0]  e_wb_val;
    logic [`RV_REG_W-1:0] e_wb_rd;
    logic                 e_wb_we;

    rv_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .req_i      (req_i),
        .inst_i     (inst_i),
        .pc_i       (pc_i),
        .rs1_val_i  (rs1_val_i),
        .rs2_val_i  (rs2_val_i),
        .wb_val_i   (wb_val_i),
        .wb_rd_i    (wb_rd_i),
        .wb_we_i    (wb_we_i),
        .ack_o      (ack_o),
        .d_valid_o  (d_valid),
        .d_class_o  (d_class),
        .d_insn_o   (d_insn),
        .d_pc_o     (d_pc),
        .d_rs1_o    (d_rs1),
        .d_rs2_o    (d_rs2),
        .d_wb_val_o (d_wb_val),
        .d_wb_rd_o  (d_wb_rd),
        .d_wb_we_o  (d_wb_we)
    );

    rv_execute u_execute (
        .clk        (clk),
        .rst        (rst),
        .d_valid_i  (d_valid),
        .d_class_i  (d_class),
        .d_insn_i   (d_insn),
        .d_pc_i     (d_pc),
        .d_rs1_i    (d_rs1),
        .d_rs2_i    (d_rs2),
        .d_wb_val_i (d_wb_val),
        .d_wb_rd_i  (d_wb_rd),
        .d_wb_we_i  (d_wb_we),
        .e_valid_o  (e_valid),
        .e_class_o  (e_class),
        .e_golden_o (e_golden),
        .e_rd_o     (e_rd),
        .e_pc_o     (e_pc),
        .e_wb_val_o (e_wb_val),
        .e_wb_rd_o  (e_wb_rd),
        .e_wb_we_o  (e_wb_we)
    );

    rv_result u_result (
        .clk             (clk),
        .rst             (rst),
        .e_valid_i       (e_valid),
        .e_class_i       (e_class),
        .e_golden_i      (e_golden),
        .e_rd_i          (e_rd),
        .e_pc_i          (e_pc),
        .e_wb_val_i      (e_wb_val),
        .e_wb_rd_i       (e_wb_rd),
        .e_wb_we_i       (e_wb_we),
        .stat_valid_o    (stat_valid_o),
        .stat_class_o    (stat_class_o),
        .stat_err_o      (stat_err_o),
        .stat_expected_o (stat_expected_o),
        .stat_actual_o   (stat_actual_o),
        .flow_valid_o    (flow_valid_o),
        .flow_err_o      (flow_err_o),
        .flow_expected_o (flow_expected_o),
        .flow_actual_o   (flow_actual_o)
    );

endmodule

`default_nettype wire

/* test/rv_chk_monitor.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_chk_defs.svh"

module rv_chk_monitor (
    input  logic                  clk,
    input  logic                  stat_valid_i,
    input  logic [`RV_CLS_W-1:0]  stat_class_i,
    input  logic                  stat_err_i,
    input  logic [`RV_XLEN-1:0]   stat_expected_i,
    input  logic [`RV_XLEN-1:0]   stat_actual_i,
    input  logic                  flow_valid_i,
    input  logic                  flow_err_i,
    input  logic [`RV_XLEN-1:0]   flow_expected_i,
    input  logic [`RV_XLEN-1:0]   flow_actual_i
);
    string               st_name[$];
    logic [`RV_CLS_W-1:0] st_cls[$];
    bit                  st_err[$];
    logic [`RV_XLEN-1:0] st_gold[$];
    logic [`RV_XLEN-1:0] st_act[$];
    string               fl_name[$];
    bit                  fl_err[$];
    logic [`RV_XLEN-1:0] fl_tgt[$];
    logic [`RV_XLEN-1:0] fl_pc[$];
    int                  pass_cnt = 0;
    int                  fail_cnt = 0;

    task automatic expect_stat(input string name, input logic [`RV_CLS_W-1:0] cls,
                               input bit err, input logic [`RV_XLEN-1:0] gold,
                               input logic [`RV_XLEN-1:0] act);
        st_name.push_back(name);
        st_cls.push_back(cls);
        st_err.push_back(err);
        st_gold.push_back(gold);
        st_act.push_back(act);
    endtask

    task automatic expect_flow(input string name, input bit err,
                               input logic [`RV_XLEN-1:0] tgt,
                               input logic [`RV_XLEN-1:0] pc);
        fl_name.push_back(name);
        fl_err.push_back(err);
        fl_tgt.push_back(tgt);
        fl_pc.push_back(pc);
    endtask

    task automatic check_stat();
        string                name;
        logic [`RV_CLS_W-1:0] cls;
        bit                   err;
        logic [`RV_XLEN-1:0]  gold;
        logic [`RV_XLEN-1:0]  act;
        bit                   reported;
        bit                   bad;
        bad = 1'b0;
        if (st_name.size() == 0) begin
            $display("status pulse arrived while no test was waiting for one");
            fail_cnt++;
        end else begin
            name = st_name.pop_front();
            cls  = st_cls.pop_front();
            err  = st_err.pop_front();
            gold = st_gold.pop_front();
            act  = st_act.pop_front();
            if (stat_class_i != cls) begin
                $display("FAILED %s class expected %0d actual %0d", name, cls, stat_class_i);
                bad = 1'b1;
            end
            if (stat_err_i != err) begin
                $display("FAILED %s error expected %0d actual %0d", name, err, stat_err_i);
                bad = 1'b1;
            end
            // expected and written values exist for write-checked and illegal words
            reported = (cls == `RV_CLS_XORI) || (cls == `RV_CLS_AUIPC) ||
                       (cls == `RV_CLS_ILLEGAL);
            if (reported && stat_expected_i != gold) begin
                $display("FAILED %s golden expected %h actual %h", name, gold, stat_expected_i);
                bad = 1'b1;
            end
            if (reported && stat_actual_i != act) begin
                $display("FAILED %s written expected %h actual %h", name, act, stat_actual_i);
                bad = 1'b1;
            end
            if (bad) begin
                fail_cnt++;
            end else begin
                $display("ok   %s (written %h)", name, stat_actual_i);
                pass_cnt++;
            end
        end
    endtask

    task automatic check_flow();
        string               name;
        bit                  err;
        logic [`RV_XLEN-1:0] tgt;
        logic [`RV_XLEN-1:0] pc;
        if (fl_name.size() == 0) begin
            $display("branch target report arrived with no branch expected");
            fail_cnt++;
        end else begin
            name = fl_name.pop_front();
            err  = fl_err.pop_front();
            tgt  = fl_tgt.pop_front();
            pc   = fl_pc.pop_front();
            if (flow_err_i != err || flow_expected_i != tgt || flow_actual_i != pc) begin
                $display("FAILED %s flow expected %h/%h/%0d actual %h/%h/%0d", name, tgt, pc,
                         err, flow_expected_i, flow_actual_i, flow_err_i);
                fail_cnt++;
            end else begin
                $display("ok   %s flow (next pc %h)", name, flow_actual_i);
                pass_cnt++;
            end
        end
    endtask

    function automatic int waiting();
        return st_name.size() + fl_name.size();
    endfunction

    // anything still queued never got its report
    task automatic check_drained();
        foreach (st_name[k]) begin
            $display("no status report ever came for %s", st_name[k]);
            fail_cnt++;
        end
        foreach (fl_name[k]) begin
            $display("no branch target report ever came for %s", fl_name[k]);
            fail_cnt++;
        end
    endtask

    always @(negedge clk) begin   // outputs settled half a cycle after the edge
        if (stat_valid_i) begin
            check_stat();
        end
        if (flow_valid_i) begin
            check_flow();
        end
    end

endmodule

`default_nettype wire

/* test/tb_rv_retire_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_chk_defs.svh"

module tb_rv_retire_checker;
    logic                 clk;
    logic                 rst;
    logic                 req_i;
    logic                 ack_o;
    logic [`RV_XLEN-1:0]  inst_i;
    logic [`RV_XLEN-1:0]  pc_i;
    logic [`RV_XLEN-1:0]  rs1_val_i;
    logic [`RV_XLEN-1:0]  rs2_val_i;
    logic [`RV_XLEN-1:0]  wb_val_i;
    logic [`RV_REG_W-1:0] wb_rd_i;
    logic                 wb_we_i;
    logic                 stat_valid_o;
    logic [`RV_CLS_W-1:0] stat_class_o;
    logic                 stat_err_o;
    logic [`RV_XLEN-1:0]  stat_expected_o;
    logic [`RV_XLEN-1:0]  stat_actual_o;
    logic                 flow_valid_o;
    logic                 flow_err_o;
    logic [`RV_XLEN-1:0]  flow_expected_o;
    logic [`RV_XLEN-1:0]  flow_actual_o;

    // stimulus table with one entry per row in each queue
    string               t_name[$];
    logic [`RV_XLEN-1:0] t_inst[$];
    logic [`RV_XLEN-1:0] t_pc[$];
    logic [`RV_XLEN-1:0] t_rs1[$];
    logic [`RV_XLEN-1:0] t_rs2[$];
    logic [`RV_XLEN-1:0] t_wbv[$];   // offset onto golden for xori/auipc, raw otherwise
    int                  t_rd[$];
    int                  t_we[$];
    int                  t_cls[$];
    int                  t_err[$];
    int                  t_ferr[$];  // flow error of the branch before this row
    logic [`RV_XLEN-1:0] t_off[$];   // branch or jump offset
    integer              seed = 32'h4c7a_290d;

    rv_retire_checker dut0 (.*);

    rv_chk_monitor mon0 (
        .clk(clk), .stat_valid_i(stat_valid_o), .stat_class_i(stat_class_o),
        .stat_err_i(stat_err_o), .stat_expected_i(stat_expected_o),
        .stat_actual_i(stat_actual_o), .flow_valid_i(flow_valid_o), .flow_err_i(flow_err_o),
        .flow_expected_i(flow_expected_o), .flow_actual_i(flow_actual_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd,
                                          input logic [6:0] op);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                          input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_u(input int imm, input int rd, input logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] off, input logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], `RV_OPC_B};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `RV_OPC_JAL};
    endfunction

    task automatic add_row(input string name, input logic [31:0] inst, input logic [31:0] pc,
                           input logic [31:0] rs1, input logic [31:0] rs2,
                           input logic [31:0] wbv, input int rd, input int we, input int cls,
                           input int err, input int ferr, input logic [31:0] off);
        t_name.push_back(name);
        t_inst.push_back(inst);
        t_pc.push_back(pc);
        t_rs1.push_back(rs1);
        t_rs2.push_back(rs2);
        t_wbv.push_back(wbv);
        t_rd.push_back(rd);
        t_we.push_back(we);
        t_cls.push_back(cls);
        t_err.push_back(err);
        t_ferr.push_back(ferr);
        t_off.push_back(off);
    endtask

    task automatic fill_table();
        logic [31:0] r0;
        logic [31:0] r1;
        r0 = $random(seed);
        r1 = $random(seed);
        // legal and illegal words of each opcode group (class 0 illegal, 1 other)
        add_row("lui", enc_u(20'h12345, 3, `RV_OPC_LUI), 'h100, 0, 0, 'h12345000, 3, 1, 1, 0, 0, 0);
        add_row("sub", enc_r(7'h20, 2, 1, 3'b000, 4, `RV_OPC_R), 'h104, 5, 3, 2, 4, 1, 1, 0, 0, 0);
        add_row("or_alt_bad", enc_r(7'h20, 2, 1, 3'b110, 4, `RV_OPC_R), 'h108, 0, 0, 0, 4, 0,
                0, 0, 0, 0);
        add_row("bad_opcode_we", 32'hffff_ffff, 'h10c, 0, 0, 9, 31, 1, 0, 1, 0, 0);
        add_row("lw", enc_i(16, 1, 3'b010, 5, `RV_OPC_IL), 'h110, 0, 0, 7, 5, 1, 1, 0, 0, 0);
        add_row("load_f3_bad", enc_i(0, 1, 3'b011, 5, `RV_OPC_IL), 'h114, 0, 0, 0, 5, 0,
                0, 0, 0, 0);
        add_row("sw", enc_r(0, 2, 1, 3'b010, 0, `RV_OPC_S), 'h118, 0, 0, 0, 0, 0, 1, 0, 0, 0);
        add_row("store_f3_bad_we", enc_r(0, 2, 1, 3'b011, 0, `RV_OPC_S), 'h11c, 0, 0, 0, 2, 1,
                0, 1, 0, 0);
        add_row("fence", enc_i('h0ff, 0, 3'b000, 0, `RV_OPC_FENCE), 'h120, 0, 0, 0, 0, 0,
                1, 0, 0, 0);
        add_row("ebreak", 32'h0010_0073, 'h124, 0, 0, 0, 0, 0, 1, 0, 0, 0);
        add_row("sys_bad_rd", enc_i(0, 0, 3'b000, 1, `RV_OPC_SYS), 'h128, 0, 0, 0, 1, 0,
                0, 0, 0, 0);
        add_row("jalr_f3_bad", enc_i(0, 1, 3'b001, 1, `RV_OPC_JALR), 'h12c, 0, 0, 0, 1, 0,
                0, 0, 0, 0);
        add_row("branch_f3_bad", enc_b(8, 3'b010), 'h130, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row("slli_alt_bad_we", enc_r(7'h20, 3, 1, 3'b001, 4, `RV_OPC_I), 'h134, 0, 0, 0, 4,
                1, 0, 1, 0, 0);
        add_row("jalr", enc_i(4, 1, 3'b000, 1, `RV_OPC_JALR), 'h138, 0, 0, 'h13c, 1, 1,
                1, 0, 0, 0);
        add_row("fence_f3_bad", enc_i(0, 0, 3'b001, 0, `RV_OPC_FENCE), 'h13c, 0, 0, 0, 0, 0,
                0, 0, 0, 0);
        // xori with random rs1 and negative immediates
        add_row("xori_ok", enc_i('hffb, 1, `RV_F3_XOR, 7, `RV_OPC_I), 'h200, r0, 0, 0, 7, 1,
                2, 0, 0, 0);
        add_row("xori_bad_val", enc_i('h800, 1, `RV_F3_XOR, 7, `RV_OPC_I), 'h204, r1, 0, 1, 7,
                1, 2, 1, 0, 0);
        add_row("xori_bad_rd", enc_i('hfff, 1, `RV_F3_XOR, 7, `RV_OPC_I), 'h208, r0, 0, 0, 8,
                1, 2, 1, 0, 0);
        add_row("xori_we_low", enc_i('hf00, 1, `RV_F3_XOR, 7, `RV_OPC_I), 'h20c, r1, 0, 0, 7,
                0, 2, 1, 0, 0);
        add_row("auipc_ok", enc_u('h80001, 9, `RV_OPC_AUIPC), 'h2000, 0, 0, 0, 9, 1, 3, 0, 0, 0);
        add_row("auipc_off_by_one", enc_u('h80001, 9, `RV_OPC_AUIPC), 'h2004, 0, 0, 1, 9, 1,
                3, 1, 0, 0);
        // each branch in this chain is checked against the row after it
        add_row("blt_taken", enc_b('h10, `RV_F3_BLT), 'h300, -3, 5, 0, 0, 0, 4, 0, 0, 'h10);
        add_row("blt_not_taken", enc_b('h20, `RV_F3_BLT), 'h310, 7, -2, 0, 0, 0, 4, 0, 0, 'h20);
        add_row("jal_back", enc_j(-32, 1), 'h314, 0, 0, 'h318, 1, 1, 5, 0, 0, -32);
        add_row("after_jal", enc_u(1, 3, `RV_OPC_LUI), 'h2f4, 0, 0, 'h1000, 3, 1, 1, 0, 0, 0);
        add_row("jal_back_again", enc_j(-32, 1), 'h600, 0, 0, 'h604, 1, 1, 5, 0, 0, -32);
        add_row("blt_after_bad_jal", enc_b('h40, `RV_F3_BLT), 'h604, -8, 1, 0, 0, 0, 4, 0, 1,
                'h40);
        add_row("after_blt_wrong", enc_u(2, 3, `RV_OPC_LUI), 'h648, 0, 0, 'h2000, 3, 1, 1, 0,
                1, 0);
    endtask

    // watchdog allows 20 cycles per row plus the reset
    initial begin
        #1;
        #(t_name.size() * 20 * 100 + 4 * 100);
        $display("watchdog expired before all rows were checked");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [`RV_CLS_W-1:0] cls;
        logic [`RV_XLEN-1:0]  gold;
        logic [`RV_XLEN-1:0]  target;
        logic [`RV_XLEN-1:0]  wbv;
        logic [`RV_XLEN-1:0]  act;
        bit                   pend;
        int                   spin;
        pend = 1'b0;
        target = '0;
        rst = 1'b1;
        req_i = 1'b0;
        inst_i = '0;
        pc_i = '0;
        rs1_val_i = '0;
        rs2_val_i = '0;
        wb_val_i = '0;
        wb_rd_i = '0;
        wb_we_i = 1'b0;
        fill_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (t_name[i]) begin
            cls = t_cls[i][2:0];
            if (cls == `RV_CLS_XORI) begin
                gold = t_rs1[i] ^ {{20{t_inst[i][31]}}, t_inst[i][31:20]};
            end else if (cls == `RV_CLS_AUIPC) begin
                gold = t_pc[i] + {t_inst[i][31:12], 12'h000};
            end else if (cls == `RV_CLS_BLT) begin
                gold = ($signed(t_rs1[i]) < $signed(t_rs2[i])) ? t_pc[i] + t_off[i]
                                                               : t_pc[i] + 4;
            end else if (cls == `RV_CLS_JAL) begin
                gold = t_pc[i] + t_off[i];
            end else begin
                gold = '0;
            end
            wbv = (cls == `RV_CLS_XORI || cls == `RV_CLS_AUIPC) ? gold + t_wbv[i]
                                                                : t_wbv[i];
            act = (cls == `RV_CLS_ILLEGAL) ? ((t_we[i] != 0) ? 32'd1 : 32'd0) : wbv;
            mon0.expect_stat(t_name[i], cls, t_err[i] != 0, gold, act);
            if (pend) begin
                mon0.expect_flow(t_name[i], t_ferr[i] != 0, target, t_pc[i]);
            end
            pend = (cls == `RV_CLS_BLT) || (cls == `RV_CLS_JAL);
            target = gold;
            @(negedge clk);
            inst_i = t_inst[i];
            pc_i = t_pc[i];
            rs1_val_i = t_rs1[i];
            rs2_val_i = t_rs2[i];
            wb_val_i = wbv;
            wb_rd_i = t_rd[i][4:0];
            wb_we_i = (t_we[i] != 0);
            req_i = 1'b1;
            @(negedge clk);
            while (!ack_o) @(negedge clk);
            req_i = 1'b0;
            while (ack_o) @(negedge clk);
        end
        spin = 0;
        while (mon0.waiting() > 0 && spin < 10) begin
            @(negedge clk);
            spin++;
        end
        mon0.check_drained();
        $display("rows %0d, checks passed %0d, failed %0d", t_name.size(), mon0.pass_cnt,
                 mon0.fail_cnt);
        if (mon0.fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
